/* hw/controlFsm.sv */
module controlFsm import cpuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  instrWord   instr,
    output instrWord   curInstr,
    output logic       instrReq,
    output logic       operandLatch,
    output logic       resultLatch,
    output logic       regWrEn,
    output logic       srcSel,
    output logic [1:0] immSel,
    output logic [2:0] aluOp,
    output logic       pcAdvance,
    output logic       branchEn,
    output logic       branchNe,
    output logic       jumpEn
);

    localparam logic [2:0] SFetch    = 3'd0;
    localparam logic [2:0] SDecode   = 3'd1;
    localparam logic [2:0] SExec     = 3'd2;
    localparam logic [2:0] SWrite    = 3'd3;
    localparam logic [2:0] SRedirect = 3'd4;

    logic [2:0] state;
    logic [2:0] nextState;
    logic       known;
    logic       isFlow;
    logic       isBranch;

    // Instruction register, loaded as the fetch state ends
    always_ff @(posedge clk) begin
        if (state == SFetch) begin
            curInstr <= instr;
        end
    end

    // Per-opcode ALU code, operand source and flow class
    always_comb begin
        aluOp  = AluAdd;
        immSel = ImmReg;
        srcSel = 1'b0;
        known  = 1'b1;
        isFlow = 1'b0;
        case (curInstr.rView.opcode)
            OpAdd:   begin srcSel = 1'b1; aluOp = AluAdd;  end
            OpSub:   begin srcSel = 1'b1; aluOp = AluSub;  end
            OpOr:    begin srcSel = 1'b1; aluOp = AluOr;   end
            OpNand:  begin srcSel = 1'b1; aluOp = AluNand; end
            OpAddi:  begin aluOp = AluAdd;  immSel = ImmSext; end
            OpAddiu: begin aluOp = AluAdd;  immSel = ImmZext; end
            OpSubi:  begin aluOp = AluSub;  immSel = ImmSext; end
            OpOri:   begin aluOp = AluOr;   immSel = ImmSext; end
            OpNandi: begin aluOp = AluNand; immSel = ImmSext; end
            OpShift: begin
                // Shift kind sits in the Rc field
                case (curInstr.rView.rc)
                    ShiftLeft:       aluOp = AluSll;
                    ShiftRightLogic: aluOp = AluSrl;
                    ShiftRightArith: aluOp = AluSra;
                    default:         known = 1'b0;
                endcase
            end
            OpBeq, OpBne: begin
                aluOp  = AluSub;
                isFlow = 1'b1;
            end
            OpJump:  isFlow = 1'b1;
            default: known = 1'b0;
        endcase
    end

    assign isBranch = (curInstr.iView.opcode == OpBeq) || (curInstr.iView.opcode == OpBne);

    always_comb begin
        case (state)
            SFetch:    nextState = SDecode;
            SDecode: begin
                if (!known) begin
                    nextState = SFetch;
                end else if (isFlow) begin
                    nextState = SRedirect;
                end else begin
                    nextState = SExec;
                end
            end
            SExec:     nextState = SWrite;
            SWrite:    nextState = SFetch;
            SRedirect: nextState = SFetch;
            default:   nextState = SFetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SFetch;
        end else begin
            state <= nextState;
        end
    end

    // Strobes follow the state directly
    assign instrReq     = (state == SFetch);
    assign pcAdvance    = (state == SFetch);
    assign operandLatch = (state == SDecode);
    assign resultLatch  = (state == SExec);
    assign regWrEn      = (state == SWrite);
    assign branchEn     = (state == SRedirect) && isBranch;
    assign branchNe     = (state == SRedirect) && (curInstr.iView.opcode == OpBne);
    assign jumpEn       = (state == SRedirect) && (curInstr.jView.opcode == OpJump);

endmodule

/* hw/cpuPkg.sv */
package cpuPkg;

    // Datapath and register number widths
    localparam int DataWidth    = 16;
    localparam int RegAddrWidth = 4;

    // Register-register group, Ra = Rb op Rc
    localparam logic [3:0] OpAdd   = 4'h8;
    localparam logic [3:0] OpSub   = 4'hC;
    localparam logic [3:0] OpNand  = 4'hB;
    localparam logic [3:0] OpOr    = 4'hF;

    // Immediate group, Ra = Ra op imm8
    localparam logic [3:0] OpAddi  = 4'h9;
    localparam logic [3:0] OpAddiu = 4'hA;
    localparam logic [3:0] OpSubi  = 4'hD;
    localparam logic [3:0] OpOri   = 4'h6;
    localparam logic [3:0] OpNandi = 4'h7;

    // Shift group, kind in the Rc field and amount in the Rb field
    localparam logic [3:0] OpShift = 4'h0;
    localparam logic [3:0] ShiftLeft       = 4'd1;
    localparam logic [3:0] ShiftRightLogic = 4'd2;
    localparam logic [3:0] ShiftRightArith = 4'd3;

    // Control flow
    localparam logic [3:0] OpBeq   = 4'h4;
    localparam logic [3:0] OpBne   = 4'h5;
    localparam logic [3:0] OpJump  = 4'h3;

    // ALU operation codes, code 7 yields zero
    localparam logic [2:0] AluAdd  = 3'd0;
    localparam logic [2:0] AluSub  = 3'd1;
    localparam logic [2:0] AluSll  = 3'd2;
    localparam logic [2:0] AluSrl  = 3'd3;
    localparam logic [2:0] AluSra  = 3'd4;
    localparam logic [2:0] AluNand = 3'd5;
    localparam logic [2:0] AluOr   = 3'd6;

    // Second ALU operand source
    localparam logic [1:0] ImmReg  = 2'd0;
    localparam logic [1:0] ImmSext = 2'd1;
    localparam logic [1:0] ImmZext = 2'd2;

    // One instruction word seen three ways
    typedef union packed {
        struct packed {
            logic [3:0]              opcode;
            logic [RegAddrWidth-1:0] ra;
            logic [RegAddrWidth-1:0] rb;
            logic [RegAddrWidth-1:0] rc;
        } rView;
        struct packed {
            logic [3:0]              opcode;
            logic [RegAddrWidth-1:0] ra;
            logic [7:0]              imm8;
        } iView;
        struct packed {
            logic [3:0]  opcode;
            logic [11:0] imm12;
        } jView;
    } instrWord;

endpackage

/* hw/cpuTop.sv */
module cpuTop import cpuPkg::*; #(
    parameter logic [DataWidth-1:0] resetPc = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    output logic [DataWidth-1:0]    pc,
    output logic                    instrReq,
    input  instrWord                instr,
    output logic                    regWrEn,
    output logic [RegAddrWidth-1:0] regWrAddr,
    output logic [DataWidth-1:0]    regWrData
);

    instrWord             curInstr;
    logic                 operandLatch;
    logic                 resultLatch;
    logic                 srcSel;
    logic [1:0]           immSel;
    logic [2:0]           aluOp;
    logic                 pcAdvance;
    logic                 branchEn;
    logic                 branchNe;
    logic                 jumpEn;
    logic [DataWidth-1:0] rdData1;
    logic [DataWidth-1:0] rdData2;
    logic [DataWidth-1:0] aluResult;
    logic                 zero;

    // Writes always target Ra and carry the latched result
    assign regWrAddr = curInstr.rView.ra;
    assign regWrData = aluResult;

    controlFsm u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .curInstr     (curInstr),
        .instrReq     (instrReq),
        .operandLatch (operandLatch),
        .resultLatch  (resultLatch),
        .regWrEn      (regWrEn),
        .srcSel       (srcSel),
        .immSel       (immSel),
        .aluOp        (aluOp),
        .pcAdvance    (pcAdvance),
        .branchEn     (branchEn),
        .branchNe     (branchNe),
        .jumpEn       (jumpEn)
    );

    regFile u_regs (
        .clk      (clk),
        .rst      (rst),
        .curInstr (curInstr),
        .srcSel   (srcSel),
        .wrEn     (regWrEn),
        .wrData   (aluResult),
        .rdData1  (rdData1),
        .rdData2  (rdData2)
    );

    pcUnit #(
        .resetPc (resetPc)
    ) u_pc (
        .clk       (clk),
        .rst       (rst),
        .curInstr  (curInstr),
        .pcAdvance (pcAdvance),
        .branchEn  (branchEn),
        .branchNe  (branchNe),
        .jumpEn    (jumpEn),
        .zero      (zero),
        .pc        (pc)
    );

    execUnit u_exec (
        .clk          (clk),
        .rst          (rst),
        .curInstr     (curInstr),
        .rdData1      (rdData1),
        .rdData2      (rdData2),
        .operandLatch (operandLatch),
        .resultLatch  (resultLatch),
        .immSel       (immSel),
        .aluOp        (aluOp),
        .aluResult    (aluResult),
        .zero         (zero)
    );

endmodule

/* hw/execUnit.sv */
module execUnit import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  instrWord             curInstr,
    input  logic [DataWidth-1:0] rdData1,
    input  logic [DataWidth-1:0] rdData2,
    input  logic                 operandLatch,
    input  logic                 resultLatch,
    input  logic [1:0]           immSel,
    input  logic [2:0]           aluOp,
    output logic [DataWidth-1:0] aluResult,
    output logic                 zero
);

    logic [DataWidth-1:0]    opA;
    logic [DataWidth-1:0]    opB;
    logic [DataWidth-1:0]    immSext;
    logic [DataWidth-1:0]    immZext;
    logic [DataWidth-1:0]    aluB;
    logic [DataWidth-1:0]    aluOut;
    logic [RegAddrWidth-1:0] shamt;

    always_ff @(posedge clk) begin
        if (rst) begin
            opA       <= '0;
            opB       <= '0;
            aluResult <= '0;
        end else begin
            if (operandLatch) begin
                opA <= rdData1;
                opB <= rdData2;
            end
            if (resultLatch) begin
                aluResult <= aluOut;
            end
        end
    end

    assign immSext = {{(DataWidth-8){curInstr.iView.imm8[7]}}, curInstr.iView.imm8};
    assign immZext = {{(DataWidth-8){1'b0}}, curInstr.iView.imm8};

    always_comb begin
        case (immSel)
            ImmSext: aluB = immSext;
            ImmZext: aluB = immZext;
            default: aluB = opB;
        endcase
    end

    // Shift amount is the Rb field itself, not the register it names
    assign shamt = curInstr.rView.rb;

    always_comb begin
        case (aluOp)
            AluAdd:  aluOut = opA + aluB;
            AluSub:  aluOut = opA - aluB;
            AluSll:  aluOut = opA << shamt;
            AluSrl:  aluOut = opA >> shamt;
            AluSra:  aluOut = $signed(opA) >>> shamt;
            AluNand: aluOut = ~(opA & aluB);
            AluOr:   aluOut = opA | aluB;
            default: aluOut = '0;
        endcase
    end

    // Live flag, sampled by the PC unit in redirect
    assign zero = (aluOut == '0);

endmodule

/* hw/pcUnit.sv */
module pcUnit import cpuPkg::*; #(
    parameter logic [DataWidth-1:0] resetPc = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  instrWord             curInstr,
    input  logic                 pcAdvance,
    input  logic                 branchEn,
    input  logic                 branchNe,
    input  logic                 jumpEn,
    input  logic                 zero,
    output logic [DataWidth-1:0] pc
);

    logic [DataWidth-1:0] branchOff;
    logic [DataWidth-1:0] jumpOff;
    logic [DataWidth-1:0] target;
    logic                 taken;

    // Word offsets, sign-extended and doubled
    assign branchOff = {{(DataWidth-RegAddrWidth-1){curInstr.rView.rc[RegAddrWidth-1]}},
                        curInstr.rView.rc, 1'b0};
    assign jumpOff   = {{(DataWidth-13){curInstr.jView.imm12[11]}},
                        curInstr.jView.imm12, 1'b0};

    // pc already holds the incremented value here
    assign target = pc + (jumpEn ? jumpOff : branchOff);

    // beq wants zero set, bne wants it clear
    assign taken = jumpEn || (branchEn && (zero ^ branchNe));

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
        end else if (pcAdvance) begin
            pc <= pc + DataWidth'(2);
        end else if (taken) begin
            pc <= target;
        end
    end

endmodule

/* hw/regFile.sv */
module regFile import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  instrWord             curInstr,
    input  logic                 srcSel,
    input  logic                 wrEn,
    input  logic [DataWidth-1:0] wrData,
    output logic [DataWidth-1:0] rdData1,
    output logic [DataWidth-1:0] rdData2
);

    logic [DataWidth-1:0]    regs [2**RegAddrWidth];
    logic [RegAddrWidth-1:0] rdAddr1;
    logic [RegAddrWidth-1:0] rdAddr2;
    logic [RegAddrWidth-1:0] wrAddr;

    // Register-register form reads Rb and Rc, all others Ra and Rb
    assign rdAddr1 = srcSel ? curInstr.rView.rb : curInstr.rView.ra;
    assign rdAddr2 = srcSel ? curInstr.rView.rc : curInstr.rView.rb;
    assign wrAddr  = curInstr.rView.ra;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**RegAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // r0 reads as zero regardless of contents
    assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

endmodule

/* src.f */
hw/cpuPkg.sv
hw/controlFsm.sv
hw/regFile.sv
hw/pcUnit.sv
hw/execUnit.sv
hw/cpuTop.sv
test/tbClock.sv
test/cpuAssert.sv
test/cpuTb.sv

/* test/cpuAssert.sv */
module cpuAssert (
    input logic clk,
    input logic rst,
    input logic instrReq,
    input logic regWrEn
);
    timeunit 1ns;
    timeprecision 100ps;

    // Read by the testbench at the end of the run
    int assertFails = 0;

    // Writeback lasts exactly one cycle
    wrSinglePulse: assert property (@(posedge clk) disable iff (rst) regWrEn |=> !regWrEn)
        else begin
            assertFails++;
            $error("regWrEn stayed high for two cycles");
        end

    // Fetch and writeback are separate states
    fetchWriteApart: assert property (@(posedge clk) disable iff (rst) !(regWrEn && instrReq))
        else begin
            assertFails++;
            $error("regWrEn and instrReq high in the same cycle");
        end

    // First cycle out of reset is a fetch
    fetchAfterReset: assert property (@(posedge clk) $fell(rst) |-> instrReq)
        else begin
            assertFails++;
            $error("instrReq low in the cycle after reset release");
        end

endmodule

bind cpuTop cpuAssert u_assert (
    .clk      (clk),
    .rst      (rst),
    .instrReq (instrReq),
    .regWrEn  (regWrEn)
);

/* test/cpuTb.sv */
module cpuTb import cpuPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumSteps     = 31;
    localparam int FetchTimeout = 8;
    localparam int WriteTimeout = 8;

    typedef struct packed {
        logic [DataWidth-1:0]    pc;
        logic [DataWidth-1:0]    word;
        logic                    wr;
        logic [RegAddrWidth-1:0] wrReg;
        logic [DataWidth-1:0]    wrVal;
    } stepRow;

    logic                    clk;
    logic                    rst;
    logic [DataWidth-1:0]    pc;
    logic                    instrReq;
    instrWord                instr;
    logic                    regWrEn;
    logic [RegAddrWidth-1:0] regWrAddr;
    logic [DataWidth-1:0]    regWrData;

    stepRow steps [NumSteps];
    int     errors;
    int     checks;
    bit     ok;

    tbClock u_clk (
        .clk (clk),
        .rst (rst)
    );

    cpuTop #(
        .resetPc (16'h0000)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .instrReq  (instrReq),
        .instr     (instr),
        .regWrEn   (regWrEn),
        .regWrAddr (regWrAddr),
        .regWrData (regWrData)
    );

    task automatic loadSteps();
        // pc, instruction, writes, register, value
        steps[0]  = '{16'h0000, {OpAddi,  4'h1, 8'h7F},       1'b1, 4'h1, 16'h007F};
        // Same imm8 sign-extended, then zero-extended
        steps[1]  = '{16'h0002, {OpAddi,  4'h2, 8'h80},       1'b1, 4'h2, 16'hFF80};
        steps[2]  = '{16'h0004, {OpAddiu, 4'h3, 8'h80},       1'b1, 4'h3, 16'h0080};
        steps[3]  = '{16'h0006, {OpAdd,   4'h4, 4'h1, 4'h2},  1'b1, 4'h4, 16'hFFFF};
        steps[4]  = '{16'h0008, {OpSub,   4'h5, 4'h3, 4'h1},  1'b1, 4'h5, 16'h0001};
        steps[5]  = '{16'h000A, {OpOr,    4'h6, 4'h1, 4'h3},  1'b1, 4'h6, 16'h00FF};
        steps[6]  = '{16'h000C, {OpNand,  4'h7, 4'h2, 4'h3},  1'b1, 4'h7, 16'hFF7F};
        steps[7]  = '{16'h000E, {OpSubi,  4'h3, 8'h01},       1'b1, 4'h3, 16'h007F};
        steps[8]  = '{16'h0010, {OpOri,   4'h5, 8'h30},       1'b1, 4'h5, 16'h0031};
        steps[9]  = '{16'h0012, {OpNandi, 4'h6, 8'h0F},       1'b1, 4'h6, 16'hFFF0};
        // Shifts of the negative value 0xFF80
        steps[10] = '{16'h0014, {OpAdd,   4'h8, 4'h2, 4'h0},  1'b1, 4'h8, 16'hFF80};
        steps[11] = '{16'h0016, {OpShift, 4'h8, 4'h4, ShiftLeft},       1'b1, 4'h8, 16'hF800};
        steps[12] = '{16'h0018, {OpAdd,   4'h9, 4'h2, 4'h0},  1'b1, 4'h9, 16'hFF80};
        steps[13] = '{16'h001A, {OpShift, 4'h9, 4'h3, ShiftRightLogic}, 1'b1, 4'h9, 16'h1FF0};
        steps[14] = '{16'h001C, {OpShift, 4'h2, 4'h3, ShiftRightArith}, 1'b1, 4'h2, 16'hFFF0};
        // Write to r0 still pulses, but r0 keeps reading zero
        steps[15] = '{16'h001E, {OpAddi,  4'h0, 8'h55},       1'b1, 4'h0, 16'h0055};
        steps[16] = '{16'h0020, {OpAdd,   4'hA, 4'h0, 4'h0},  1'b1, 4'hA, 16'h0000};
        // r1 equals r3, r2 differs from r1
        steps[17] = '{16'h0022, {OpBeq,   4'h1, 4'h3, 4'h2},  1'b0, 4'h0, 16'h0000};
        steps[18] = '{16'h0028, {OpBne,   4'h1, 4'h3, 4'h3},  1'b0, 4'h0, 16'h0000};
        steps[19] = '{16'h002A, {OpBeq,   4'h1, 4'h2, 4'h1},  1'b0, 4'h0, 16'h0000};
        steps[20] = '{16'h002C, {OpBne,   4'h1, 4'h2, 4'h1},  1'b0, 4'h0, 16'h0000};
        steps[21] = '{16'h0030, {OpJump,  12'h003},           1'b0, 4'h0, 16'h0000};
        steps[22] = '{16'h0038, {OpAddi,  4'hB, 8'h11},       1'b1, 4'hB, 16'h0011};
        // Back into the slot the first jump skipped
        steps[23] = '{16'h003A, {OpJump,  12'hFFB},           1'b0, 4'h0, 16'h0000};
        steps[24] = '{16'h0032, {OpAddi,  4'hC, 8'h22},       1'b1, 4'hC, 16'h0022};
        steps[25] = '{16'h0034, {OpJump,  12'h003},           1'b0, 4'h0, 16'h0000};
        steps[26] = '{16'h003C, {OpAdd,   4'hD, 4'hB, 4'hC},  1'b1, 4'hD, 16'h0033};
        // Opcode 1 is undefined
        steps[27] = '{16'h003E, 16'h1234,                     1'b0, 4'h0, 16'h0000};
        steps[28] = '{16'h0040, {OpOr,    4'hE, 4'hD, 4'h6},  1'b1, 4'hE, 16'hFFF3};
        // Opcode 2 is undefined as well
        steps[29] = '{16'h0042, 16'h2000,                     1'b0, 4'h0, 16'h0000};
        steps[30] = '{16'h0044, {OpSubi,  4'hF, 8'h01},       1'b1, 4'hF, 16'hFFFF};
    endtask

    task automatic checkWord(input string name, input logic [DataWidth-1:0] got,
                             input logic [DataWidth-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkReg(input string name, input logic [RegAddrWidth-1:0] got,
                            input logic [RegAddrWidth-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic waitFetch(output bit found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < FetchTimeout) begin
            @(negedge clk);
            cycles++;
            if (regWrEn) begin
                errors++;
                $display("Unexpected register write at %0t to r%0d", $time, regWrAddr);
            end
            found = instrReq;
        end
        if (!found) begin
            errors++;
            $display("Timeout at %0t: no fetch within %0d cycles", $time, FetchTimeout);
        end
    endtask

    task automatic waitWrite(input stepRow row, output bit found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < WriteTimeout) begin
            @(negedge clk);
            cycles++;
            found = regWrEn;
        end
        if (found) begin
            checkReg("regWrAddr", regWrAddr, row.wrReg);
            checkWord("regWrData", regWrData, row.wrVal);
        end else begin
            errors++;
            $display("Timeout at %0t: no register write within %0d cycles", $time, WriteTimeout);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        ok     = 1'b1;
        instr  = '0;
        loadSteps();
        // Fetch holds through reset, so row 0 can go out before rst drops
        for (int i = 0; i < NumSteps && ok; i++) begin
            waitFetch(ok);
            if (ok) begin
                checkWord("pc", pc, steps[i].pc);
                instr = steps[i].word;
                if (steps[i].wr) begin
                    waitWrite(steps[i], ok);
                end
            end
        end
        errors += u_dut.u_assert.assertFails;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* test/tbClock.sv */
module tbClock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HalfPeriod  = 10;
    localparam int ResetCycles = 2;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // Two rising edges with rst high, then release on a falling edge
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule
